//--- Makefile
# Verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= icache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_TEXT ?= Something failed

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard source/*.sv source/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the verdict; a crashed simulator counts as a failure too
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_TEXT)" $(LOG); then \
	  echo "Simulation run did not pass, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- icache.f
+incdir+source
source/icache_pkg.sv
source/icache_prefetch.sv
source/icache_mem.sv
source/icache_top.sv
verif/icache_checker.sv
verif/icache_tb.sv

//--- source/icache_mem.sv
// Direct-mapped, one 8-byte line per index; a fill is visible to lookups from the next cycle
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_mem
(
  input  logic                      clock,
  input  logic                      reset,
  input  icache_pkg::cache_lookup_t lookup,
  input  icache_pkg::cache_fill_t   fill,
  output icache_pkg::cache_rd_t     rd
);

  import icache_pkg::*;

  line_data_t               data_mem [`ICACHE_LINES];
  cache_tag_t               tag_mem  [`ICACHE_LINES];
  logic [`ICACHE_LINES-1:0] line_valid;

  line_data_t               rd_data;
  cache_tag_t               rd_tag;
  logic                     rd_valid;

  // Read the addressed line
  assign rd_data  = data_mem[lookup.idx];
  assign rd_tag   = tag_mem[lookup.idx];
  assign rd_valid = line_valid[lookup.idx];

  always_comb
  begin
    rd.hit  = rd_valid && (rd_tag == lookup.tag);
    rd.data = rd_data;
  end

  // Line payload
  always_ff @(posedge clock)
  begin
    if (fill.we)
    begin
      data_mem[fill.idx] <= fill.data;
      tag_mem[fill.idx]  <= fill.tag;                         // Replaces whatever lived here
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      line_valid <= '0;
    else if (fill.we)
      line_valid[fill.idx] <= 1'b1;
  end

  // Valid bits are all clear once reset has been seen
  hit_after_reset: assert property (@(posedge clock) $past(reset) |-> !rd.hit);

endmodule

`default_nettype wire

//--- source/icache_params.svh
// Widths assume 8-byte lines with address bits 31..3 split into tag and index; upper bits ignored
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Cache geometry
`define ICACHE_IDX_BITS 7                     // 128 lines
`define ICACHE_TAG_BITS 22                    // Tag plus index span bits 31..3
`define ICACHE_LINES    (1 << `ICACHE_IDX_BITS)

// Memory bus
`define MEM_TAG_BITS    4                     // Tag 0 means no transaction
`define ADDR_BITS       64                    // Fetch and memory address width

`endif

//--- source/icache_pkg.sv
// Bus and cache types; memory tag 0 is reserved and never names a transaction
`default_nettype none

`include "icache_params.svh"

package icache_pkg;

  typedef logic [63:0]                  line_data_t;
  typedef logic [`ADDR_BITS-1:0]        addr_t;
  typedef logic [`MEM_TAG_BITS-1:0]     mem_tag_t;
  typedef logic [`ICACHE_IDX_BITS-1:0]  cache_idx_t;
  typedef logic [`ICACHE_TAG_BITS-1:0]  cache_tag_t;

  typedef enum logic [1:0]
  {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2                          // Never issued by the fetch path
  } bus_cmd_e;

  typedef struct packed
  {
    bus_cmd_e cmd;
    addr_t    addr;                           // Always 8-byte aligned
  } mem_req_t;

  typedef struct packed
  {
    mem_tag_t   response;                     // Acceptance tag, 0 on refusal
    line_data_t data;                         // Valid when tag is nonzero
    mem_tag_t   tag;                          // Tag of returning data
  } mem_resp_t;

  typedef struct packed
  {
    cache_idx_t idx;
    cache_tag_t tag;
  } cache_lookup_t;

  typedef struct packed
  {
    logic       hit;
    line_data_t data;
  } cache_rd_t;

  typedef struct packed
  {
    logic       we;
    cache_idx_t idx;
    cache_tag_t tag;
    line_data_t data;
  } cache_fill_t;

endpackage

`default_nettype wire

//--- source/icache_prefetch.sv
// Assumes memory never reuses a tag before its data returns; stream stays at most 15 lines ahead
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_prefetch
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      stall,
  input  logic [`ADDR_BITS-1:0]     fetch_addr,
  input  icache_pkg::mem_resp_t     mem_resp,
  input  icache_pkg::cache_rd_t     rd,
  output icache_pkg::mem_req_t      mem_req,
  output icache_pkg::cache_lookup_t lookup,
  output icache_pkg::cache_fill_t   fill,
  output logic [63:0]               fetch_data,
  output logic                      fetch_valid
);

  import icache_pkg::*;

  localparam int unsigned TAG_COUNT = 1 << `MEM_TAG_BITS;
  localparam int unsigned MAX_AHEAD = TAG_COUNT - 1;          // One line per usable tag
  localparam int unsigned LINE_BITS = `ADDR_BITS - 3;
  localparam int unsigned IDX_LO    = 3;
  localparam int unsigned IDX_HI    = IDX_LO + `ICACHE_IDX_BITS - 1;
  localparam int unsigned TAG_LO    = IDX_HI + 1;
  localparam int unsigned TAG_HI    = TAG_LO + `ICACHE_TAG_BITS - 1;

  addr_t                fetch_line;
  addr_t                stream_base;
  logic [LINE_BITS-1:0] line_cnt;
  logic                 prev_miss;
  addr_t                next_addr;
  addr_t                ahead;
  logic                 in_window;
  logic                 ahead_ok;
  logic                 forward;
  logic                 miss_now;
  logic                 line_pending;
  logic                 lost;
  logic                 restart;
  logic                 req_en;
  logic                 accepted;
  logic [TAG_COUNT-1:0] pending;                              // One bit per memory tag
  addr_t                req_addr [TAG_COUNT];
  addr_t                fill_addr;

  assign fetch_line = {fetch_addr[`ADDR_BITS-1:3], 3'b000};

  always_comb
  begin
    lookup.idx = fetch_addr[IDX_HI:IDX_LO];
    lookup.tag = fetch_addr[TAG_HI:TAG_LO];
  end

  // Stream window and lookahead
  assign next_addr = stream_base + {line_cnt, 3'b000};
  assign ahead     = next_addr - fetch_line;
  assign in_window = (fetch_line >= stream_base) && (fetch_line <= next_addr);
  assign ahead_ok  = in_window && (ahead < `ADDR_BITS'(MAX_AHEAD * 8));

  // Returning data for the waiting fetch bypasses the storage
  assign forward     = pending[mem_resp.tag] && (req_addr[mem_resp.tag] == fetch_line);
  assign fetch_valid = forward || rd.hit;
  assign fetch_data  = forward ? mem_resp.data : rd.data;
  assign miss_now    = !fetch_valid;

  always_comb
  begin
    line_pending = 1'b0;
    for (int i = 1; i < TAG_COUNT; i++)
    begin
      if (pending[i] && (req_addr[i] == fetch_line))
        line_pending = 1'b1;                                  // Already on its way
    end
  end

  // A line behind the stream head that is neither cached nor in flight was evicted
  assign lost    = miss_now && prev_miss && !line_pending && (fetch_line < next_addr);
  assign restart = !in_window || lost;

  assign req_en   = !stall && ahead_ok && !lost;
  assign accepted = req_en && (mem_resp.response != '0);

  always_comb
  begin
    mem_req.cmd  = (reset || !req_en) ? BUS_NONE : BUS_LOAD;
    mem_req.addr = next_addr;
  end

  // Fill target comes from the address recorded with the tag
  assign fill_addr = req_addr[mem_resp.tag];

  always_comb
  begin
    fill.we   = pending[mem_resp.tag];
    fill.idx  = fill_addr[IDX_HI:IDX_LO];
    fill.tag  = fill_addr[TAG_HI:TAG_LO];
    fill.data = mem_resp.data;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      stream_base <= '0;
      line_cnt    <= '0;
      prev_miss   <= 1'b0;
      pending     <= '0;
    end
    else
    begin
      if (fill.we)
        pending[mem_resp.tag] <= 1'b0;                        // Entry retires on return
      if (accepted)
        pending[mem_resp.response] <= 1'b1;                   // Wins if the tag is reused now
      if (!stall)
        prev_miss <= miss_now;
      if (restart)
      begin
        stream_base <= fetch_line;                            // New stream at the fetch line
        line_cnt    <= '0;
      end
      else if (accepted)
        line_cnt <= line_cnt + 1'b1;
    end
  end

  always_ff @(posedge clock)
  begin
    if (accepted)
      req_addr[mem_resp.response] <= next_addr;
  end

  // Tag 0 is never recorded as pending, so no fill can come from it
  fill_tag_nonzero: assert property (@(posedge clock) disable iff (reset)
    fill.we |-> (mem_resp.tag != '0));

  no_store_cmd: assert property (@(posedge clock) mem_req.cmd != BUS_STORE);

endmodule

`default_nettype wire

//--- source/icache_top.sv
// Fetch hits are combinational; misses complete on forwarded data or on a hit after the fill
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_top
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  stall,                        // Fetch stage hold
  input  logic [`ADDR_BITS-1:0] fetch_addr,
  input  icache_pkg::mem_resp_t mem_resp,
  output icache_pkg::mem_req_t  mem_req,
  output logic [63:0]           fetch_data,
  output logic                  fetch_valid
);

  import icache_pkg::*;

  cache_lookup_t lookup;                                      // Fetch address split
  cache_rd_t     rd;                                          // Lookup result
  cache_fill_t   fill;                                        // Returning line

  icache_prefetch icache_prefetch_i
  (
    .clock       (clock),
    .reset       (reset),
    .stall       (stall),
    .fetch_addr  (fetch_addr),
    .mem_resp    (mem_resp),
    .rd          (rd),
    .mem_req     (mem_req),
    .lookup      (lookup),
    .fill        (fill),
    .fetch_data  (fetch_data),
    .fetch_valid (fetch_valid)
  );

  icache_mem icache_mem_i
  (
    .clock  (clock),
    .reset  (reset),
    .lookup (lookup),
    .fill   (fill),
    .rd     (rd)
  );

endmodule

`default_nettype wire

//--- verif/icache_checker.sv
// Checks fetched words against the address rule below 4 GiB; test context comes from the testbench
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_checker
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  fetch_new,                    // First cycle of a fetch
  input  logic [`ADDR_BITS-1:0] fetch_addr,
  input  logic [63:0]           fetch_data,
  input  logic                  fetch_valid,
  output int                    fail_count
);

  localparam logic [31:0] UPPER_KEY = 32'h5A3C_96E1;          // Mixed into the upper half

  string test_name     = "idle";
  logic  hit_only      = 1'b0;
  int    test_fails    = 0;
  int    fail_total    = 0;
  int    words_checked = 0;
  int    tests_run     = 0;
  int    tests_failed  = 0;

  assign fail_count = fail_total;

  // Memory word for the aligned address
  function automatic logic [63:0] expected_word(input logic [`ADDR_BITS-1:0] addr);
    logic [31:0] low;
    low = {addr[31:3], 3'b000};
    return {low ^ UPPER_KEY, low};
  endfunction

  always @(posedge clock)
  begin
    if (!reset)
    begin
      if (fetch_valid === 1'b1)
      begin
        words_checked++;
        if (fetch_data !== expected_word(fetch_addr))
        begin
          $display("Error in %s at address %h: expected %h, actual %h",
                   test_name, fetch_addr, expected_word(fetch_addr), fetch_data);
          test_fails++;
          fail_total++;
        end
      end
      else if (hit_only && fetch_new)
      begin
        $display("%s: fetch at address %h missed although its line should be cached",
                 test_name, fetch_addr);
        test_fails++;
        fail_total++;
      end
    end
  end

  task automatic start_test(input string name, input logic hit);
    test_name  = name;
    hit_only   = hit;                                         // Every fetch must hit at once
    test_fails = 0;
  endtask

  task automatic fetch_stuck(input int index, input logic [`ADDR_BITS-1:0] addr);
    $display("%s: fetch %0d at address %h never completed", test_name, index, addr);
    test_fails++;
    fail_total++;
  endtask

  task automatic finish_test(input int fetches);
    tests_run++;
    if (test_fails == 0)
      $display("%s: passed, %0d fetches", test_name, fetches);
    else
    begin
      tests_failed++;
      $display("%s: FAILED, %0d problems in %0d fetches", test_name, test_fails, fetches);
    end
    hit_only = 1'b0;
  endtask

  task automatic print_summary();
    $display("Tests run %0d, failed %0d, words checked %0d, problems %0d",
             tests_run, tests_failed, words_checked, fail_total);
  endtask

endmodule

`default_nettype wire

//--- verif/icache_tb.sv
// Memory model serves any aligned address below 4 GiB from a fixed rule with 2 to 9 cycles latency
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_tb;

  import icache_pkg::*;

  localparam int          NUM_TESTS    = 6;
  localparam int          RESET_CYCLES = 8;
  localparam int          TAGS         = 1 << `MEM_TAG_BITS;
  localparam logic [31:0] JUMP_OFFSET  = 32'h0001_2340;       // Far outside any stream window
  localparam logic [31:0] UPPER_KEY    = 32'h5A3C_96E1;
  localparam logic [15:0] LFSR_TAPS    = 16'hB400;
  localparam logic [15:0] LFSR_SEED    = 16'd77;

  typedef struct packed
  {
    logic [31:0] start;
    int          step;                                        // Bytes between fetches
    int          jump_every;                                  // Fetches per jump, 0 for none
    int          count;
    int          stall_len;                                   // Stalled cycles in every 16
    int          refuse;                                      // Refusals in every 8 offers
    logic        hit_only;
    int          limit;                                       // Cycle budget of the test
  } test_row_t;

  // Columns: start, step, jump_every, count, stall_len, refuse, hit_only, limit
  test_row_t rows [NUM_TESTS] = '{
    '{32'h0000_1000, 8, 0,  1, 0, 0, 1'b0,   60},
    '{32'h0000_1000, 0, 0,  4, 0, 0, 1'b1,   20},
    '{32'h0002_0000, 8, 0, 64, 0, 0, 1'b0,  600},
    '{32'h0040_0000, 8, 8, 48, 0, 1, 1'b0,  900},
    '{32'h0060_0000, 8, 0, 40, 0, 6, 1'b0, 1500},
    '{32'h0080_0004, 4, 0, 48, 6, 2, 1'b0, 1200}
  };

  string test_names [NUM_TESTS] = '{"cold_miss", "hit_after_fill", "sequential_stream",
                                    "jump_restart", "memory_backpressure", "fetch_stall"};

  logic                  clock;
  logic                  reset;
  logic                  stall;
  logic                  fetch_new;
  logic [`ADDR_BITS-1:0] fetch_addr;
  mem_resp_t             mem_resp = '0;
  mem_req_t              mem_req;
  logic [63:0]           fetch_data;
  logic                  fetch_valid;
  int                    fail_count;

  logic [15:0]           lfsr_q = LFSR_SEED;
  logic [TAGS-1:0]       busy;                                // Tags with data still owed
  logic [`ADDR_BITS-1:0] tag_addr [TAGS];
  int                    due [TAGS];
  int                    cycle;
  int                    refuse_level;
  mem_resp_t             resp_next = '0;

  icache_top icache_top_i
  (
    .clock       (clock),
    .reset       (reset),
    .stall       (stall),
    .fetch_addr  (fetch_addr),
    .mem_resp    (mem_resp),
    .mem_req     (mem_req),
    .fetch_data  (fetch_data),
    .fetch_valid (fetch_valid)
  );

  icache_checker checker_i
  (
    .clock       (clock),
    .reset       (reset),
    .fetch_new   (fetch_new),
    .fetch_addr  (fetch_addr),
    .fetch_data  (fetch_data),
    .fetch_valid (fetch_valid),
    .fail_count  (fail_count)
  );

  initial
  begin
    clock = 1'b0;
    forever #5 clock = ~clock;                                // 10 ns period
  end

  // Galois LFSR, one step per bit taken
  function automatic int rand_bits(input int n);
    int   value;
    logic out_bit;
    value = 0;
    for (int i = 0; i < n; i++)
    begin
      out_bit = lfsr_q[0];
      lfsr_q  = {1'b0, lfsr_q[15:1]} ^ (out_bit ? LFSR_TAPS : 16'h0000);
      value   = {value[30:0], out_bit};
    end
    return value;
  endfunction

  function automatic logic [63:0] mem_word(input logic [`ADDR_BITS-1:0] addr);
    logic [31:0] low;
    low = {addr[31:3], 3'b000};
    return {low ^ UPPER_KEY, low};
  endfunction

  function automatic logic [31:0] next_fetch(input test_row_t row, input logic [31:0] addr,
                                             input int done);
    logic [31:0] next;
    next = addr + row.step;
    if (row.jump_every != 0 && done % row.jump_every == 0)
      next = next + JUMP_OFFSET;
    return next;
  endfunction

  // Memory model bookkeeping, answer for the coming cycle is chosen here
  always @(posedge clock)
  begin
    int       first;
    int       pick;
    mem_tag_t t;
    if (reset)
    begin
      busy      = '0;
      cycle     = 0;
      resp_next = '0;
    end
    else
    begin
      cycle++;
      if (mem_resp.tag != '0)
        busy[mem_resp.tag] = 1'b0;                            // Data delivered, tag free
      if (mem_req.cmd == BUS_LOAD && mem_resp.response != '0)
      begin
        busy[mem_resp.response]     = 1'b1;
        tag_addr[mem_resp.response] = mem_req.addr;
        due[mem_resp.response]      = cycle + 1 + rand_bits(3);
      end
      resp_next = '0;
      if (rand_bits(3) >= refuse_level)
      begin
        first = rand_bits(4);
        for (int k = 0; k < TAGS; k++)
        begin
          pick = (first + k) % TAGS;
          t    = pick[`MEM_TAG_BITS-1:0];
          if (resp_next.response == '0 && t != '0 && !busy[t])
            resp_next.response = t;
        end
      end
      for (int k = 1; k < TAGS; k++)
      begin
        t = k[`MEM_TAG_BITS-1:0];
        if (resp_next.tag == '0 && busy[t] && due[t] <= cycle)
        begin
          resp_next.tag  = t;
          resp_next.data = mem_word(tag_addr[t]);
        end
      end
    end
  end

  always @(negedge clock)
    mem_resp <= resp_next;

  initial
  begin : main
    logic [31:0] cur_addr;
    int          done_cnt;
    int          row_cycle;
    logic        new_flag;
    reset        = 1'b1;
    stall        = 1'b0;
    fetch_new    = 1'b0;
    fetch_addr   = '0;
    refuse_level = 0;
    repeat (RESET_CYCLES) @(negedge clock);
    reset = 1'b0;
    for (int r = 0; r < NUM_TESTS; r++)
    begin
      checker_i.start_test(test_names[r], rows[r].hit_only);
      refuse_level = rows[r].refuse;
      cur_addr     = rows[r].start;
      done_cnt     = 0;
      row_cycle    = 0;
      new_flag     = 1'b1;
      while (done_cnt < rows[r].count && row_cycle < rows[r].limit)
      begin
        fetch_addr = {32'h0, cur_addr};
        fetch_new  = new_flag;
        stall      = (row_cycle % 16) >= (16 - rows[r].stall_len);  // Burst at end of window
        @(posedge clock);
        row_cycle++;
        new_flag = 1'b0;
        if (fetch_valid === 1'b1 && !stall)
        begin
          done_cnt++;
          cur_addr = next_fetch(rows[r], cur_addr, done_cnt);
          new_flag = 1'b1;
        end
        @(negedge clock);
      end
      stall     = 1'b0;
      fetch_new = 1'b0;
      if (done_cnt < rows[r].count)
        checker_i.fetch_stuck(done_cnt, {32'h0, cur_addr});
      checker_i.finish_test(done_cnt);
    end
    checker_i.print_summary();
    if (fail_count == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  initial
  begin : watchdog
    int budget;
    budget = RESET_CYCLES + 2 * NUM_TESTS + 10;
    for (int r = 0; r < NUM_TESTS; r++)
      budget += rows[r].limit;
    repeat (budget) @(posedge clock);
    $display("Watchdog expired after %0d cycles, the run did not finish", budget);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire
